/* include/dot_accel_defs.svh */
`ifndef DOT_ACCEL_DEFS_SVH
`define DOT_ACCEL_DEFS_SVH

// operand width, both multiplicands
`define DA_OP_W         16

// elements per segment in the MAC core
`define DA_SEG_LEN      4

// element counter inside one segment
`define DA_SEG_CNT_W    2

// completed-batch counter, wraps
`define DA_BATCH_CNT_W  8

`endif

/* source/dot_accel_types_pkg.sv */
`include "dot_accel_defs.svh"

package dot_accel_types_pkg;

    // segment result is one word, batch total is two words
    localparam int SEG_W = 32;
    localparam int SUM_W = 2 * SEG_W;

    // one signed input operand
    typedef logic signed [`DA_OP_W-1:0] operand_t;

    // signed partial result of one segment
    typedef logic signed [SEG_W-1:0] seg_result_t;

    // signed batch total, upper and lower word
    typedef logic signed [SUM_W-1:0] batch_sum_t;

endpackage

/* source/dot_accel_ctrl_pkg.sv */
package dot_accel_ctrl_pkg;

    // per-element opcode
    typedef enum logic {
        MAC_ADD = 1'b0,
        MAC_SUB = 1'b1
    } mac_op_e;

    // batch sequencer state
    // IDLE until the first element of a batch shows up
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } seq_state_e;

endpackage

/* source/mac_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_accel_defs.svh"

module mac_core (
    input  wire                                clk,
    input  wire                                arst_n,
    input  logic                               in_v,
    input  logic                               in_last,
    input  dot_accel_types_pkg::operand_t      in_a,
    input  dot_accel_types_pkg::operand_t      in_b,
    input  dot_accel_ctrl_pkg::mac_op_e        in_op,
    output logic                               seg_v,
    output logic                               seg_last,
    output dot_accel_types_pkg::seg_result_t   seg_result
);

    import dot_accel_types_pkg::*;
    import dot_accel_ctrl_pkg::*;

    // index of the last element of a full segment
    localparam logic [`DA_SEG_CNT_W-1:0] LAST_IDX = `DA_SEG_CNT_W'(`DA_SEG_LEN - 1);

    seg_result_t               prod;
    seg_result_t               term;
    seg_result_t               seg_acc;
    logic [`DA_SEG_CNT_W-1:0]  elem_cnt;
    logic                      seg_close;

    ////////////////////////////////////////////////////////////
    // product and signed term
    ////////////////////////////////////////////////////////////

    // 16x16 signed product fits one word
    assign prod = seg_result_t'(in_a * in_b);

    // MAC_SUB negates before accumulation
    always_comb begin
        term = prod;
        if (in_op == MAC_SUB) begin
            term = -prod;
        end
    end

    // segment closes on a full count or on the batch end
    assign seg_close = in_v && (in_last || (elem_cnt == LAST_IDX));

    ////////////////////////////////////////////////////////////
    // running segment accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_acc  <= '0;
            elem_cnt <= '0;
        end else if (in_v) begin
            if (seg_close) begin
                // restart from zero, the closed sum goes out below
                seg_acc  <= '0;
                elem_cnt <= '0;
            end else begin
                seg_acc  <= seg_acc + term;
                elem_cnt <= elem_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // segment result output
    ////////////////////////////////////////////////////////////

    // one-cycle strobe after the closing element
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_v    <= 1'b0;
            seg_last <= 1'b0;
        end else begin
            seg_v    <= seg_close;
            seg_last <= seg_close && in_last;
        end
    end

    // payload, only meaningful with seg_v
    always_ff @(posedge clk) begin
        if (seg_close) begin
            seg_result <= seg_acc + term;
        end
    end

endmodule

`default_nettype wire

/* source/batch_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_accel_defs.svh"

module batch_sequencer (
    input  wire                          clk,
    input  wire                          arst_n,
    input  logic                         seg_v,
    input  logic                         seg_last,
    input  logic                         in_v,
    output logic                         s_fin,
    output logic                         p,
    output logic                         rd_ok,
    output logic [`DA_BATCH_CNT_W-1:0]   batch_cnt
);

    import dot_accel_ctrl_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    ////////////////////////////////////////////////////////////
    // batch end
    ////////////////////////////////////////////////////////////

    // final segment result of a batch
    // a batch is always running when it arrives
    assign s_fin = seg_v && seg_last && (state == RUN);

    ////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_v) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                // next batch may start right away
                if (s_fin && !in_v) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // bank select, batch count, readable flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p         <= 1'b0;
            batch_cnt <= '0;
            rd_ok     <= 1'b0;
        end else if (s_fin) begin
            // flip to the other bank for the next batch
            p         <= ~p;
            batch_cnt <= batch_cnt + 1'b1;
            // sticky once a total exists
            rd_ok     <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/dst_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module dst_buf (
    input  wire                                clk,
    input  wire                                arst_n,
    input  logic                               seg_v,
    input  logic                               s_fin,
    input  logic                               p,
    input  dot_accel_types_pkg::seg_result_t   seg_result,
    input  logic                               rd_v,
    input  logic                               rd_ok,
    output logic                               res_v,
    output dot_accel_types_pkg::batch_sum_t    res_d
);

    import dot_accel_types_pkg::*;

    // one accumulator and one finished total per bank
    batch_sum_t  acc [2];
    batch_sum_t  tot [2];
    batch_sum_t  seg_ext;
    logic [1:0]  bank_hit;
    logic        rd_fire;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    // signed cast keeps the sign
    assign seg_ext = batch_sum_t'(seg_result);

    // one-hot of the bank being filled
    assign bank_hit = p ? 2'b10 : 2'b01;

    ////////////////////////////////////////////////////////////
    // per-bank accumulate and end-of-batch latch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < 2; b++) begin
                acc[b] <= '0;
                tot[b] <= '0;
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (s_fin && bank_hit[b]) begin
                    // last segment folds straight into the total
                    tot[b] <= acc[b] + seg_ext;
                    acc[b] <= '0;
                end else if (seg_v && bank_hit[b]) begin
                    acc[b] <= acc[b] + seg_ext;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // readout
    ////////////////////////////////////////////////////////////

    // nothing to return before the first batch
    assign rd_fire = rd_v && rd_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_v <= 1'b0;
        end else begin
            res_v <= rd_fire;
        end
    end

    // p has already flipped, so !p is the bank just finished
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            res_d <= tot[!p];
        end
    end

endmodule

`default_nettype wire

/* source/dot_accel_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_accel_defs.svh"

module dot_accel_top (
    input  wire                                clk,
    input  wire                                arst_n,
    // element stream
    input  logic                               in_v,
    input  dot_accel_types_pkg::operand_t      in_a,
    input  dot_accel_types_pkg::operand_t      in_b,
    input  dot_accel_ctrl_pkg::mac_op_e        in_op,
    input  logic                               in_last,
    // read port
    input  logic                               rd_v,
    output logic                               res_v,
    output dot_accel_types_pkg::batch_sum_t    res_d,
    // status
    output logic                               batch_done,
    output logic                               bank,
    output logic [`DA_BATCH_CNT_W-1:0]         batch_cnt
);

    import dot_accel_types_pkg::*;

    // core to sequencer and buffer
    logic         seg_v;
    logic         seg_last;
    seg_result_t  seg_result;

    // sequencer to buffer
    logic         rd_ok;

    ////////////////////////////////////////////////////////////
    // segment MAC
    ////////////////////////////////////////////////////////////

    mac_core u_mac_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_v       (in_v),
        .in_last    (in_last),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_op      (in_op),
        .seg_v      (seg_v),
        .seg_last   (seg_last),
        .seg_result (seg_result)
    );

    ////////////////////////////////////////////////////////////
    // batch control
    ////////////////////////////////////////////////////////////

    // batch end strobe and bank select go straight out
    batch_sequencer u_batch_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .seg_v      (seg_v),
        .seg_last   (seg_last),
        .in_v       (in_v),
        .s_fin      (batch_done),
        .p          (bank),
        .rd_ok      (rd_ok),
        .batch_cnt  (batch_cnt)
    );

    ////////////////////////////////////////////////////////////
    // ping-pong result buffer
    ////////////////////////////////////////////////////////////

    dst_buf u_dst_buf (
        .clk        (clk),
        .arst_n     (arst_n),
        .seg_v      (seg_v),
        .s_fin      (batch_done),
        .p          (bank),
        .seg_result (seg_result),
        .rd_v       (rd_v),
        .rd_ok      (rd_ok),
        .res_v      (res_v),
        .res_d      (res_d)
    );

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low over five rising edges
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

/* bench/dot_accel_props.sv */
`timescale 1ns/1ps

module dot_accel_props (
    input logic clk,
    input logic arst_n,
    input logic in_v,
    input logic rd_v,
    input logic rd_ok,
    input logic res_v,
    input logic batch_done,
    input logic bank,
    input logic seg_v
);

    // failure count, read back by the testbench
    int err_cnt = 0;

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // response is the read strobe one cycle late
    a_rd_resp: assert property (@(posedge clk) disable iff (!arst_n)
        $past(rd_ok) |-> (res_v == $past(rd_v)))
    else begin
        err_cnt++;
        $error("res_v is not rd_v delayed by one cycle");
    end

    // no response before the first finished batch
    a_rd_early: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(rd_ok) |-> !res_v)
    else begin
        err_cnt++;
        $error("res_v raised while rd_ok was low");
    end

    ////////////////////////////////////////////////////////////
    // bank and segment strobes
    ////////////////////////////////////////////////////////////

    // ping-pong flips only at batch end
    a_bank_flip: assert property (@(posedge clk) disable iff (!arst_n)
        bank == ($past(bank) ^ $past(batch_done)))
    else begin
        err_cnt++;
        $error("bank changed without batch_done, or held through it");
    end

    // lone element gives a single seg_v pulse
    a_seg_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (in_v && !$past(in_v)) ##1 !in_v |=> !(seg_v && $past(seg_v)))
    else begin
        err_cnt++;
        $error("seg_v lasted two cycles after a lone input");
    end

endmodule

/* bench/dot_accel_tb.sv */
`timescale 1ns/1ps

`include "dot_accel_defs.svh"

module dot_accel_tb;

    import dot_accel_types_pkg::*;
    import dot_accel_ctrl_pkg::*;

    // longest wait for any DUT response in cycles
    localparam int WAIT_MAX = 40;

    logic                        clk;
    logic                        arst_n;
    logic                        in_v;
    operand_t                    in_a;
    operand_t                    in_b;
    mac_op_e                     in_op;
    logic                        in_last;
    logic                        rd_v;
    logic                        res_v;
    batch_sum_t                  res_d;
    logic                        batch_done;
    logic                        bank;
    logic [`DA_BATCH_CNT_W-1:0]  batch_cnt;

    // expected status, random state, queued elements
    logic                        exp_bank;
    logic [`DA_BATCH_CNT_W-1:0]  exp_cnt;
    logic [31:0]                 rng;
    operand_t                    q_a [$];
    operand_t                    q_b [$];
    mac_op_e                     q_op [$];
    logic                        q_last [$];

    clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dot_accel_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_v       (in_v),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_op      (in_op),
        .in_last    (in_last),
        .rd_v       (rd_v),
        .res_v      (res_v),
        .res_d      (res_d),
        .batch_done (batch_done),
        .bank       (bank),
        .batch_cnt  (batch_cnt)
    );

    bind dot_accel_top dot_accel_props u_props (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_v       (in_v),
        .rd_v       (rd_v),
        .rd_ok      (rd_ok),
        .res_v      (res_v),
        .batch_done (batch_done),
        .bank       (bank),
        .seg_v      (seg_v)
    );

    ////////////////////////////////////////////////////////////
    // error exits and compares
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string msg);
        $display("FAIL @%0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic run_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_sum(input batch_sum_t got, input batch_sum_t exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s total %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_bank(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s bank %0b, expected %0b", what, got, exp));
        end
    endtask

    task automatic check_cnt(input logic [`DA_BATCH_CNT_W-1:0] got,
                             input logic [`DA_BATCH_CNT_W-1:0] exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s batch_cnt %0d, expected %0d", what, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers and reference model
    ////////////////////////////////////////////////////////////

    // inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic clear_queue();
        q_a.delete();
        q_b.delete();
        q_op.delete();
        q_last.delete();
    endtask

    task automatic push_elem(input int a, input int b, input mac_op_e op, input logic last);
        q_a.push_back(operand_t'(a));
        q_b.push_back(operand_t'(b));
        q_op.push_back(op);
        q_last.push_back(last);
    endtask

    // 64-bit signed sum of a*b with MAC_SUB negated
    function automatic batch_sum_t model_sum(input int lo, input int n);
        batch_sum_t acc;
        batch_sum_t prod;
        acc = '0;
        for (int i = lo; i < lo + n; i++) begin
            prod = batch_sum_t'(q_a[i]) * batch_sum_t'(q_b[i]);
            acc  = (q_op[i] == MAC_SUB) ? acc - prod : acc + prod;
        end
        return acc;
    endfunction

    // one element per cycle without gaps
    task automatic send_elems();
        for (int i = 0; i < q_a.size(); i++) begin
            in_v    = 1'b1;
            in_a    = q_a[i];
            in_b    = q_b[i];
            in_op   = q_op[i];
            in_last = q_last[i];
            step();
        end
    endtask

    task automatic stop_input();
        in_v    = 1'b0;
        in_last = 1'b0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (arst_n !== 1'b1) begin
            if (n == WAIT_MAX) begin
                run_error("reset was never released");
            end
            step();
            n++;
        end
        step();
    endtask

    task automatic wait_batch_done();
        int n;
        n = 0;
        while (batch_done !== 1'b1) begin
            if (n == WAIT_MAX) begin
                run_error("timeout waiting for batch_done");
            end
            step();
            n++;
        end
    endtask

    task automatic read_total(output batch_sum_t got);
        int n;
        n = 0;
        rd_v = 1'b1;
        step();
        rd_v = 1'b0;
        while (res_v !== 1'b1) begin
            if (n == WAIT_MAX) begin
                run_error("timeout waiting for res_v after a read");
            end
            step();
            n++;
        end
        got = res_d;
    endtask

    // bank and count after batch_done then read back the total
    task automatic verify_batch(input batch_sum_t exp, input string what,
                                output batch_sum_t got);
        wait_batch_done();
        step();
        exp_bank = ~exp_bank;
        exp_cnt  = exp_cnt + `DA_BATCH_CNT_W'(1);
        check_bank(bank, exp_bank, what);
        check_cnt(batch_cnt, exp_cnt, what);
        read_total(got);
        check_sum(got, exp, what);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_bank(bank, 1'b0, "after reset");
        check_cnt(batch_cnt, '0, "after reset");
        rd_v = 1'b1;
        step();
        rd_v = 1'b0;
        for (int n = 0; n < 5; n++) begin
            if (res_v !== 1'b0) begin
                run_error("a read before the first batch returned a response");
            end
            step();
        end
    endtask

    task automatic test_single_add();
        batch_sum_t exp;
        batch_sum_t got;
        clear_queue();
        for (int i = 0; i < 8; i++) begin
            push_elem(i * 1000 - 3000, 7 - i * 5, MAC_ADD, i == 7);
        end
        exp = model_sum(0, 8);
        send_elems();
        stop_input();
        // strobe due exactly one cycle after in_last
        if (batch_done !== 1'b1) begin
            run_error("batch_done did not follow in_last by one cycle");
        end
        verify_batch(exp, "single add", got);
    endtask

    task automatic test_sub_sign();
        batch_sum_t exp;
        batch_sum_t got;
        clear_queue();
        // two large negative segments with a total below -2^31
        push_elem(-30000, 30000, MAC_ADD, 1'b0);
        push_elem(30000, 30000, MAC_SUB, 1'b0);
        push_elem(-5, 7, MAC_ADD, 1'b0);
        push_elem(100, -3, MAC_SUB, 1'b0);
        push_elem(-32768, 32767, MAC_ADD, 1'b0);
        push_elem(20000, 20000, MAC_SUB, 1'b0);
        push_elem(-1, -1, MAC_SUB, 1'b1);
        exp = model_sum(0, 7);
        send_elems();
        stop_input();
        verify_batch(exp, "sub and sign", got);
    endtask

    task automatic test_back_to_back();
        batch_sum_t exp1;
        batch_sum_t exp2;
        batch_sum_t got1;
        batch_sum_t got2;
        clear_queue();
        for (int i = 0; i < 5; i++) begin
            push_elem(i * 300 - 700, 41 - i * 9, (i % 2) ? MAC_SUB : MAC_ADD, i == 4);
        end
        // second batch starts the cycle after in_last
        for (int i = 0; i < 7; i++) begin
            push_elem(50 - i * 123, i * 77 - 200, MAC_ADD, i == 6);
        end
        exp1 = model_sum(0, 5);
        exp2 = model_sum(5, 7);
        fork
            begin
                send_elems();
                stop_input();
            end
            begin
                verify_batch(exp1, "back to back first", got1);
                verify_batch(exp2, "back to back second", got2);
            end
        join
    endtask

    task automatic test_random_ragged();
        int          len;
        logic [31:0] ra;
        logic [31:0] rb;
        batch_sum_t  exp;
        batch_sum_t  got;
        for (int k = 0; k < 20; k++) begin
            clear_queue();
            len = 1 + int'(next_rand() % 32'd11);
            // 15-bit operands keep each segment inside one word
            for (int i = 0; i < len; i++) begin
                ra = next_rand();
                rb = next_rand();
                push_elem(int'($signed(ra[14:0])), int'($signed(rb[14:0])),
                          rb[31] ? MAC_SUB : MAC_ADD, i == len - 1);
            end
            exp = model_sum(0, len);
            send_elems();
            stop_input();
            verify_batch(exp, $sformatf("random batch %0d", k), got);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        in_v     = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_op    = MAC_ADD;
        in_last  = 1'b0;
        rd_v     = 1'b0;
        exp_bank = 1'b0;
        exp_cnt  = '0;
        rng      = 32'h72cb_9946;
        wait_reset();
        test_reset_state();
        test_single_add();
        test_sub_sign();
        test_back_to_back();
        test_random_ragged();
        step();
        if (DUT.u_props.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            run_error("bound assertions reported failures");
        end
    end

endmodule

/* verilog.f */
+incdir+include
source/dot_accel_types_pkg.sv
source/dot_accel_ctrl_pkg.sv
source/mac_core.sv
source/batch_sequencer.sv
source/dst_buf.sv
source/dot_accel_top.sv
bench/clk_gen.sv
bench/dot_accel_props.sv
bench/dot_accel_tb.sv

/* Bender.yml */
package:
  name: dot_accel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dot_accel_types_pkg.sv
      - source/dot_accel_ctrl_pkg.sv
      - source/mac_core.sv
      - source/batch_sequencer.sv
      - source/dst_buf.sv
      - source/dot_accel_top.sv
      - target: test
        files:
          - bench/clk_gen.sv
          - bench/dot_accel_props.sv
          - bench/dot_accel_tb.sv
